// ==== Bender.yml ====
package:
  name: ddr3_sched

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ddr3_sched_pkg.sv
      - rtl/ddr3_req_decode.sv
      - rtl/ddr3_cmd_fsm.sv
      - rtl/ddr3_timing_gate.sv
      - rtl/ddr3_sched_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/ddr3_sched_chk.sv
      - dv/ddr3_sched_tb.sv

// ==== all.f ====
+incdir+rtl
rtl/ddr3_sched_pkg.sv
rtl/ddr3_req_decode.sv
rtl/ddr3_cmd_fsm.sv
rtl/ddr3_timing_gate.sv
rtl/ddr3_sched_top.sv
dv/ddr3_sched_chk.sv
dv/ddr3_sched_tb.sv

// ==== dv/ddr3_sched_chk.sv ====
`timescale 1ns/1ps

module ddr3_sched_chk (
  input logic        clock,
  input logic        rst_n,
  input logic        hold_req_i,
  input logic        hold_rdy_i,
  input logic [23:0] hold_data_i,
  input logic [2:0]  ack_i
);

  // Number of failed assertions in this instance
  int unsigned fail_cnt = 0;

  default disable iff (!rst_n);

  // Command waiting for ready keeps its request and fields
  property hold_stable;
    @(posedge clock) hold_req_i && !hold_rdy_i |=> hold_req_i && $stable(hold_data_i);
  endproperty
  assert property (hold_stable)
    else begin
      $error("data-layer command changed while stalled");
      fail_cnt++;
    end

  // Each ack is a single-cycle pulse
  for (genvar i = 0; i < 3; i++) begin : g_ack
    assert property (@(posedge clock) ack_i[i] |=> !ack_i[i])
      else begin
        $error("ack %0d longer than one cycle", i);
        fail_cnt++;
      end
  end

  // Never two ports acked together
  assert property (@(posedge clock) $onehot0(ack_i))
    else begin
      $error("more than one ack high");
      fail_cnt++;
    end

endmodule

bind ddr3_timing_gate ddr3_sched_chk ddr3_sched_chk_gate (
  .clock       (clock),
  .rst_n       (rst_n),
  .hold_req_i  (ddl_req_o),
  .hold_rdy_i  (ddl_rdy_i),
  .hold_data_i ({ddl_cmd_o, ddl_ba_o, ddl_adr_o, ddl_tid_o, ddl_seq_o}),
  .ack_i       (3'b000)
);

bind ddr3_req_decode ddr3_sched_chk ddr3_sched_chk_decode (
  .clock       (clock),
  .rst_n       (rst_n),
  .hold_req_i  (1'b0),
  .hold_rdy_i  (1'b1),
  .hold_data_i (24'h0),
  .ack_i       ({wr_ack_o, rd_ack_o, byp_ack_o})
);

// ==== dv/ddr3_sched_tb.sv ====
`timescale 1ns/1ps
`include "ddr3_sched_macros.svh"

module ddr3_sched_tb
  import ddr3_sched_pkg::*;
();

  // Nine columns per data line
  localparam int NCOL = 9;
  localparam int MAX_WORDS = NCOL * 64;

  logic                        clock;
  logic                        rst_n;
  logic                        wr_req_i, rd_req_i, byp_req_i;
  logic                        wr_lst_i, rd_lst_i, byp_lst_i;
  logic [`DDR3_TID_BITS-1:0]   wr_tid_i, rd_tid_i, byp_tid_i;
  logic [`DDR3_ADDR_BITS-1:0]  wr_adr_i, rd_adr_i, byp_adr_i;
  logic                        wr_ack_o, rd_ack_o, byp_ack_o;
  logic                        ddl_req_o;
  ddr3_cmd_t                   ddl_cmd_o;
  logic [`DDR3_BANK_BITS-1:0]  ddl_ba_o;
  logic [`DDR3_ROW_BITS-1:0]   ddl_adr_o;
  logic [`DDR3_TID_BITS-1:0]   ddl_tid_o;
  logic                        ddl_seq_o;
  logic                        ddl_rdy_i;
  logic                        ddl_ref_i;

  logic [31:0] tdat [MAX_WORDS];
  logic [31:0] rnd;
  int          nlines;
  int          cyc;
  int          limit;
  // Cycle of the last ACTIVATE, closing access and REFRESH
  int          act_cyc, close_cyc, refr_cyc;

  ddr3_sched_top ddr3_sched_top_inst (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] field(input int line, input int col);
    return tdat[line * NCOL + col];
  endfunction

  function automatic logic ack_of(input int p);
    case (p)
      1:       return byp_ack_o;
      2:       return rd_ack_o;
      default: return wr_ack_o;
    endcase
  endfunction

  function automatic string ack_name(input int p);
    case (p)
      1:       return "byp_ack_o";
      2:       return "rd_ack_o";
      default: return "wr_ack_o";
    endcase
  endfunction

  // Failed assertions summed over both bound protocol checkers
  function automatic int assertion_errors();
    return ddr3_sched_top_inst.ddr3_timing_gate_inst.ddr3_sched_chk_gate.fail_cnt +
           ddr3_sched_top_inst.ddr3_req_decode_inst.ddr3_sched_chk_decode.fail_cnt;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  // Present a beat on one request port, or drop its request
  task automatic drive_port(input int p, input logic on, input int line);
    case (p)
      1: begin
        byp_req_i = on;
        byp_lst_i = 1'(field(line, 2));
        byp_tid_i = `DDR3_TID_BITS'(field(line, 3));
        byp_adr_i = `DDR3_ADDR_BITS'(field(line, 4));
      end
      2: begin
        rd_req_i = on;
        rd_lst_i = 1'(field(line, 2));
        rd_tid_i = `DDR3_TID_BITS'(field(line, 3));
        rd_adr_i = `DDR3_ADDR_BITS'(field(line, 4));
      end
      default: begin
        wr_req_i = on;
        wr_lst_i = 1'(field(line, 2));
        wr_tid_i = `DDR3_TID_BITS'(field(line, 3));
        wr_adr_i = `DDR3_ADDR_BITS'(field(line, 4));
      end
    endcase
  endtask

  // Compare one accepted command with its expected line and check gaps
  task automatic check_accept(input int line);
    logic is_acc;
    logic exp_seq;
    is_acc  = ddl_cmd_o == CMD_READ || ddl_cmd_o == CMD_WRIT;
    exp_seq = field(line, 1) != 0 ? !field(line, 2) : 1'b0;
    check_value("ddl_cmd_o", ddl_cmd_o, field(line, 5));
    check_value("ddl_ba_o", ddl_ba_o, field(line, 6));
    check_value("ddl_adr_o", ddl_adr_o, field(line, 7));
    check_value("ddl_tid_o", ddl_tid_o, field(line, 8));
    check_value("ddl_seq_o", ddl_seq_o, exp_seq);
    if (cyc - refr_cyc < `DDR3_T_RFC) begin
      abort_run("A command followed REFRESH before tRFC had passed");
    end
    if (is_acc && cyc - act_cyc < `DDR3_T_RCD) begin
      abort_run("An access followed ACTIVATE before tRCD had passed");
    end
    if (!is_acc && cyc - close_cyc < `DDR3_T_RP) begin
      abort_run("A command followed an auto-precharge access before tRP had passed");
    end
    if (ddl_cmd_o == CMD_ACTV) act_cyc = cyc;
    if (ddl_cmd_o == CMD_REFR) refr_cyc = cyc;
    if (is_acc && ddl_adr_o[`DDR3_AP_BIT]) close_cyc = cyc;
  endtask

  // Run all lines of one scenario until every command and ack is seen
  task automatic run_scenario(input int tag, input int first, input int last);
    int   exp_q [$];
    int   beat_q [4][$];
    logic ack_seen [4];
    logic ref_armed;
    logic ref_drop;
    int   acc_port;
    int   next_port;
    int   scyc;
    int   idx;
    ref_armed = 1'b0;
    ref_drop  = 1'b0;
    acc_port  = 0;
    scyc      = 0;
    for (int p = 0; p < 4; p++) begin
      ack_seen[p] = 1'b0;
    end
    for (int l = first; l <= last; l++) begin
      exp_q.push_back(l);
      if (field(l, 1) != 0) beat_q[field(l, 1)].push_back(l);
      if (field(l, 5) == CMD_REFR) ref_armed = 1'b1;
    end
    while (exp_q.size() != 0 || beat_q[1].size() != 0 || beat_q[2].size() != 0 ||
           beat_q[3].size() != 0) begin
      @(negedge clock);
      // Requests follow the level-request, one-cycle-ack handshake
      for (int p = 1; p < 4; p++) begin
        if (ack_seen[p]) begin
          void'(beat_q[p].pop_front());
        end
        if (beat_q[p].size() != 0) begin
          drive_port(p, 1'b1, beat_q[p][0]);
        end else begin
          drive_port(p, 1'b0, first);
        end
      end
      // Refresh rises once the bypass beat has had a cycle to reach the slot
      if (ref_armed && scyc == 1) ddl_ref_i = 1'b1;
      if (ref_drop) begin
        ddl_ref_i = 1'b0;
        ref_drop  = 1'b0;
      end
      rnd = xorshift32(rnd);
      ddl_rdy_i = (tag == 5) ? (rnd[1:0] != 2'b00) : 1'b1;
      #1;
      // Acks come exactly one cycle after an accepted access
      for (int p = 1; p < 4; p++) begin
        check_value(ack_name(p), ack_of(p), acc_port == p);
        ack_seen[p] = ack_of(p);
      end
      if (assertion_errors() != 0) begin
        abort_run("A protocol assertion on the data-layer or ack interface failed");
      end
      next_port = 0;
      if (ddl_req_o && ddl_rdy_i) begin
        if (exp_q.size() == 0) begin
          abort_run("The scheduler issued a command that was not expected");
        end
        idx = exp_q.pop_front();
        check_accept(idx);
        if (ddl_cmd_o == CMD_READ || ddl_cmd_o == CMD_WRIT) next_port = field(idx, 1);
        if (ddl_cmd_o == CMD_REFR) ref_drop = 1'b1;
      end
      acc_port = next_port;
      cyc++;
      scyc++;
      if (cyc > limit) begin
        abort_run("Timeout: the scheduler stopped issuing commands or acks");
      end
    end
    // Let the FSM settle back into IDLE
    repeat (4) @(negedge clock);
    cyc += 4;
  endtask

  initial begin
    int first;
    {wr_req_i, rd_req_i, byp_req_i} = '0;
    {wr_lst_i, rd_lst_i, byp_lst_i} = '0;
    {wr_tid_i, rd_tid_i, byp_tid_i} = '0;
    {wr_adr_i, rd_adr_i, byp_adr_i} = '0;
    ddl_rdy_i = 1'b1;
    ddl_ref_i = 1'b0;
    rst_n     = 1'b0;
    rnd       = 32'h137566b5;
    cyc       = 0;
    act_cyc   = -100;
    close_cyc = -100;
    refr_cyc  = -100;
    for (int i = 0; i < MAX_WORDS; i++) tdat[i] = 32'hffffffff;
    $readmemh("dv/ddr3_sched_testdata.txt", tdat);
    nlines = 0;
    while (nlines < 64 && field(nlines, 0) != 32'hffffffff) nlines++;
    if (nlines == 0) abort_run("The test data file is missing or empty");
    limit = nlines * `DDR3_T_RFC * 4 + 200;
    repeat (4) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
    first = 0;
    for (int i = 0; i < nlines; i++) begin
      if (i == nlines - 1 || field(i + 1, 0) != field(i, 0)) begin
        run_scenario(field(i, 0), first, i);
        first = i + 1;
      end
    end
    if (assertion_errors() != 0) begin
      abort_run("A protocol assertion on the data-layer or ack interface failed");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== dv/ddr3_sched_testdata.txt ====
// tag port(0 none,1 byp,2 rd,3 wr) lst tid req_adr | exp: cmd ba ddl_adr tid
// port 0 lines only expect a command, cmd 3 ACT, 5 READ, 4 WRIT, 1 REFR
1 0 0 1 000000 3 2 0123 1
1 2 1 1 048D05 5 2 0428 1
2 0 0 3 000000 3 5 0456 3
2 3 0 3 115A90 4 5 0080 3
2 3 0 4 115A91 4 5 0088 4
2 3 0 5 115A92 4 5 0090 5
2 3 1 6 115A93 4 5 0498 6
3 0 0 7 000000 3 1 0010 7
3 1 1 7 004081 5 1 0408 7
3 0 0 8 000000 3 3 0020 8
3 2 1 8 008182 5 3 0410 8
3 0 0 9 000000 3 6 0030 9
3 3 1 9 00C37F 4 6 07F8 9
4 0 0 A 000000 3 7 1FFF A
4 1 1 A 7FFFC0 5 7 0600 A
4 0 0 0 000000 1 0 0000 0
4 0 0 B 000000 3 0 0001 B
4 2 1 B 000400 5 0 0400 B
5 0 0 C 000000 3 4 0ABC C
5 2 1 C 2AF233 5 4 0598 C
5 0 0 D 000000 3 2 0321 D
5 3 0 D 0C8508 4 2 0040 D
5 3 1 E 0C8509 4 2 0448 E

// ==== rtl/ddr3_cmd_fsm.sv ====
`timescale 1ns/1ps
`include "ddr3_sched_macros.svh"

module ddr3_cmd_fsm
  import ddr3_sched_pkg::*;
(
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic                        slot_vld_i,
  input  ddr3_port_t                  slot_port_i,
  input  logic                        slot_lst_i,
  input  logic [`DDR3_TID_BITS-1:0]   slot_tid_i,
  input  logic [`DDR3_BANK_BITS-1:0]  slot_bank_i,
  input  logic [`DDR3_ROW_BITS-1:0]   slot_row_i,
  input  logic [`DDR3_COL_BITS-1:0]   slot_col_i,
  output logic                        slot_take_o,
  output logic                        seq_open_o,
  output ddr3_port_t                  seq_port_o,
  output logic                        beat_done_o,
  output ddr3_port_t                  beat_port_o,
  input  logic                        ddl_ref_i,
  output logic                        cmd_req_o,
  output ddr3_cmd_t                   cmd_o,
  output logic [`DDR3_BANK_BITS-1:0]  cmd_ba_o,
  output logic [`DDR3_ROW_BITS-1:0]   cmd_adr_o,
  output logic [`DDR3_TID_BITS-1:0]   cmd_tid_o,
  output logic                        cmd_seq_o,
  input  logic                        gate_acc_i
);

  ddr3_state_t                 state_q;

  // Open sequence, captured from the slot along with the ACTIVATE
  ddr3_port_t                  seq_port_q;
  logic [`DDR3_BANK_BITS-1:0]  seq_bank_q;
  logic                        beat_lst_q;
  logic [`DDR3_TID_BITS-1:0]   beat_tid_q;
  logic [`DDR3_COL_BITS-1:0]   beat_col_q;

  logic                        byp_pending_w;
  logic                        ref_go_w;
  logic                        act_go_w;
  logic                        pop_w;
  ddr3_cmd_t                   acc_cmd_w;

  // Burst aligned column sits above A2..A0, auto-precharge on A10
  function automatic logic [`DDR3_ROW_BITS-1:0] access_adr(
    input logic [`DDR3_COL_BITS-1:0] col,
    input logic                      ap
  );
    logic [`DDR3_ROW_BITS-1:0] adr;
    adr = '0;
    adr[`DDR3_AP_BIT-1 -: `DDR3_COL_BITS] = col;
    adr[`DDR3_AP_BIT] = ap;
    return adr;
  endfunction

  // Bypass beat beats refresh, refresh beats read and write
  assign byp_pending_w = slot_vld_i && slot_port_i == PORT_BYP;
  assign ref_go_w      = state_q == ST_IDLE && ddl_ref_i && !byp_pending_w;
  assign act_go_w      = state_q == ST_IDLE && slot_vld_i && !ref_go_w;

  // Next beat of the open sequence, only once the previous one has left
  assign pop_w = state_q == ST_ACCESS && !cmd_req_o && slot_vld_i &&
                 slot_port_i == seq_port_q;

  assign acc_cmd_w   = (seq_port_q == PORT_WR) ? CMD_WRIT : CMD_READ;
  assign slot_take_o = act_go_w || pop_w;

  // Sequence opens in the same cycle the slot is taken
  // so decode cannot refill the slot from another port
  assign seq_open_o  = act_go_w || state_q == ST_ACTV || state_q == ST_ACCESS;
  assign seq_port_o  = act_go_w ? slot_port_i : seq_port_q;

  // Completed beat, acked by decode on the next cycle
  assign beat_done_o = state_q == ST_ACCESS && gate_acc_i;
  assign beat_port_o = seq_port_q;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      cmd_req_o <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (ref_go_w) begin
            state_q   <= ST_REFR;
            cmd_req_o <= 1'b1;
          end else if (act_go_w) begin
            state_q   <= ST_ACTV;
            cmd_req_o <= 1'b1;
          end
        end
        ST_ACTV: begin
          // First access follows at once, the gate holds it for tRCD
          if (gate_acc_i) begin
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          if (gate_acc_i) begin
            cmd_req_o <= 1'b0;
            // cmd_seq low marks the last beat
            if (!cmd_seq_o) begin
              state_q <= ST_IDLE;
            end
          end else if (pop_w) begin
            cmd_req_o <= 1'b1;
          end
        end
        ST_REFR: begin
          // Wait for acceptance, then for the data layer to release refresh
          if (gate_acc_i) begin
            cmd_req_o <= 1'b0;
          end else if (!cmd_req_o && !ddl_ref_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q   <= ST_IDLE;
          cmd_req_o <= 1'b0;
        end
      endcase
    end
  end

  // Command fields change only when a new command is loaded
  always_ff @(posedge clock) begin
    if (ref_go_w) begin
      cmd_o     <= CMD_REFR;
      cmd_ba_o  <= '0;
      cmd_adr_o <= '0;
      cmd_tid_o <= '0;
      cmd_seq_o <= 1'b0;
    end else if (act_go_w) begin
      cmd_o      <= CMD_ACTV;
      cmd_ba_o   <= slot_bank_i;
      cmd_adr_o  <= slot_row_i;
      cmd_tid_o  <= slot_tid_i;
      cmd_seq_o  <= 1'b0;
      seq_port_q <= slot_port_i;
      seq_bank_q <= slot_bank_i;
      beat_lst_q <= slot_lst_i;
      beat_tid_q <= slot_tid_i;
      beat_col_q <= slot_col_i;
    end else if (state_q == ST_ACTV && gate_acc_i) begin
      cmd_o     <= acc_cmd_w;
      cmd_ba_o  <= seq_bank_q;
      cmd_adr_o <= access_adr(beat_col_q, beat_lst_q);
      cmd_tid_o <= beat_tid_q;
      cmd_seq_o <= !beat_lst_q;
    end else if (pop_w) begin
      // Same bank and row as the open sequence
      cmd_o     <= acc_cmd_w;
      cmd_ba_o  <= seq_bank_q;
      cmd_adr_o <= access_adr(slot_col_i, slot_lst_i);
      cmd_tid_o <= slot_tid_i;
      cmd_seq_o <= !slot_lst_i;
    end
  end

endmodule

// ==== rtl/ddr3_req_decode.sv ====
`timescale 1ns/1ps
`include "ddr3_sched_macros.svh"

module ddr3_req_decode
  import ddr3_sched_pkg::*;
(
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic                        wr_req_i,
  input  logic                        wr_lst_i,
  input  logic [`DDR3_TID_BITS-1:0]   wr_tid_i,
  input  logic [`DDR3_ADDR_BITS-1:0]  wr_adr_i,
  input  logic                        rd_req_i,
  input  logic                        rd_lst_i,
  input  logic [`DDR3_TID_BITS-1:0]   rd_tid_i,
  input  logic [`DDR3_ADDR_BITS-1:0]  rd_adr_i,
  input  logic                        byp_req_i,
  input  logic                        byp_lst_i,
  input  logic [`DDR3_TID_BITS-1:0]   byp_tid_i,
  input  logic [`DDR3_ADDR_BITS-1:0]  byp_adr_i,
  output logic                        wr_ack_o,
  output logic                        rd_ack_o,
  output logic                        byp_ack_o,
  input  logic                        seq_open_i,
  input  ddr3_port_t                  seq_port_i,
  input  logic                        slot_take_i,
  input  logic                        beat_done_i,
  input  ddr3_port_t                  beat_port_i,
  output logic                        slot_vld_o,
  output ddr3_port_t                  slot_port_o,
  output logic                        slot_lst_o,
  output logic [`DDR3_TID_BITS-1:0]   slot_tid_o,
  output logic [`DDR3_BANK_BITS-1:0]  slot_bank_o,
  output logic [`DDR3_ROW_BITS-1:0]   slot_row_o,
  output logic [`DDR3_COL_BITS-1:0]   slot_col_o
);

  // Index 0 is bypass, 1 is read, 2 is write, which is also the priority
  logic [2:0]                 req_w;
  logic [2:0]                 lst_w;
  logic [`DDR3_TID_BITS-1:0]  tid_w [3];
  logic [`DDR3_ADDR_BITS-1:0] adr_w [3];
  logic [2:0]                 elig_w;
  logic [2:0]                 busy_q;
  logic [2:0]                 ack_q;
  logic [1:0]                 sel_w;
  ddr3_port_t                 grant_w;

  function automatic ddr3_port_t idx_port(input int unsigned idx);
    ddr3_port_t port;
    case (idx)
      0:       port = PORT_BYP;
      1:       port = PORT_RD;
      default: port = PORT_WR;
    endcase
    return port;
  endfunction

  assign req_w    = {wr_req_i, rd_req_i, byp_req_i};
  assign lst_w    = {wr_lst_i, rd_lst_i, byp_lst_i};
  assign tid_w[0] = byp_tid_i;
  assign tid_w[1] = rd_tid_i;
  assign tid_w[2] = wr_tid_i;
  assign adr_w[0] = byp_adr_i;
  assign adr_w[1] = rd_adr_i;
  assign adr_w[2] = wr_adr_i;

  // Busy ports hold a beat that is in the slot or in flight until its ack
  // An open sequence locks the slot to its own port
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      elig_w[i] = req_w[i] && !busy_q[i] &&
                  (!seq_open_i || seq_port_i == idx_port(i));
    end
  end

  // Fixed priority, scanned low to high so the highest port wins
  always_comb begin
    grant_w = PORT_NONE;
    sel_w   = 2'd0;
    if (!slot_vld_o || slot_take_i) begin
      for (int i = 2; i >= 0; i--) begin
        if (elig_w[i]) begin
          grant_w = idx_port(i);
          sel_w   = 2'(i);
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      slot_vld_o <= 1'b0;
    end else if (grant_w != PORT_NONE) begin
      slot_vld_o <= 1'b1;
    end else if (slot_take_i) begin
      slot_vld_o <= 1'b0;
    end
  end

  // Beat payload, address split as {row, bank, column}
  always_ff @(posedge clock) begin
    if (grant_w != PORT_NONE) begin
      slot_port_o <= grant_w;
      slot_lst_o  <= lst_w[sel_w];
      slot_tid_o  <= tid_w[sel_w];
      {slot_row_o, slot_bank_o, slot_col_o} <= adr_w[sel_w];
    end
  end

  // Ack one cycle after the access is accepted, busy drops with the ack
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      busy_q <= '0;
      ack_q  <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        ack_q[i] <= beat_done_i && beat_port_i == idx_port(i);
        if (grant_w == idx_port(i)) begin
          busy_q[i] <= 1'b1;
        end else if (ack_q[i]) begin
          busy_q[i] <= 1'b0;
        end
      end
    end
  end

  assign {wr_ack_o, rd_ack_o, byp_ack_o} = ack_q;

endmodule

// ==== rtl/ddr3_sched_macros.svh ====
`ifndef DDR3_SCHED_MACROS_SVH
`define DDR3_SCHED_MACROS_SVH

// Row address width, also the width of the data-layer address bus
`define DDR3_ROW_BITS 13

// Column bits carried by a request, already burst aligned
`define DDR3_COL_BITS 7

// Bank address width
`define DDR3_BANK_BITS 3

// Request address is {row, bank, column}
`define DDR3_ADDR_BITS 23

// Transaction ID width
`define DDR3_TID_BITS 4

// ACTIVATE to READ/WRITE, in clock cycles
`define DDR3_T_RCD 3
// Auto-precharge access to next ACTIVATE or REFRESH
`define DDR3_T_RP 3
// REFRESH to any following command
`define DDR3_T_RFC 8

// A10 carries the auto-precharge flag on READ/WRITE
`define DDR3_AP_BIT 10

`endif

// ==== rtl/ddr3_sched_pkg.sv ====
package ddr3_sched_pkg;

  // DDR3 command on {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    CMD_MODE = 3'b000,
    CMD_REFR = 3'b001,
    CMD_PREC = 3'b010,
    CMD_ACTV = 3'b011,
    CMD_WRIT = 3'b100,
    CMD_READ = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOOP = 3'b111
  } ddr3_cmd_t;

  // Request port that owns a beat or a sequence
  typedef enum logic [1:0] {
    PORT_NONE = 2'd0,
    PORT_BYP  = 2'd1,
    PORT_RD   = 2'd2,
    PORT_WR   = 2'd3
  } ddr3_port_t;

  // Command FSM states
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_ACTV   = 3'd1,
    ST_ACCESS = 3'd2,
    ST_REFR   = 3'd3
  } ddr3_state_t;

endpackage

// ==== rtl/ddr3_sched_top.sv ====
`timescale 1ns/1ps
`include "ddr3_sched_macros.svh"

module ddr3_sched_top
  import ddr3_sched_pkg::*;
(
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic                        wr_req_i,
  input  logic                        wr_lst_i,
  input  logic [`DDR3_TID_BITS-1:0]   wr_tid_i,
  input  logic [`DDR3_ADDR_BITS-1:0]  wr_adr_i,
  output logic                        wr_ack_o,
  input  logic                        rd_req_i,
  input  logic                        rd_lst_i,
  input  logic [`DDR3_TID_BITS-1:0]   rd_tid_i,
  input  logic [`DDR3_ADDR_BITS-1:0]  rd_adr_i,
  output logic                        rd_ack_o,
  input  logic                        byp_req_i,
  input  logic                        byp_lst_i,
  input  logic [`DDR3_TID_BITS-1:0]   byp_tid_i,
  input  logic [`DDR3_ADDR_BITS-1:0]  byp_adr_i,
  output logic                        byp_ack_o,
  output logic                        ddl_req_o,
  output ddr3_cmd_t                   ddl_cmd_o,
  output logic [`DDR3_BANK_BITS-1:0]  ddl_ba_o,
  output logic [`DDR3_ROW_BITS-1:0]   ddl_adr_o,
  output logic [`DDR3_TID_BITS-1:0]   ddl_tid_o,
  output logic                        ddl_seq_o,
  input  logic                        ddl_rdy_i,
  input  logic                        ddl_ref_i
);

  // Slot between decode and FSM
  logic                        slot_vld;
  ddr3_port_t                  slot_port;
  logic                        slot_lst;
  logic [`DDR3_TID_BITS-1:0]   slot_tid;
  logic [`DDR3_BANK_BITS-1:0]  slot_bank;
  logic [`DDR3_ROW_BITS-1:0]   slot_row;
  logic [`DDR3_COL_BITS-1:0]   slot_col;
  logic                        slot_take;
  logic                        seq_open;
  ddr3_port_t                  seq_port;
  logic                        beat_done;
  ddr3_port_t                  beat_port;

  // Held command between FSM and gate
  logic                        cmd_req;
  ddr3_cmd_t                   cmd;
  logic [`DDR3_BANK_BITS-1:0]  cmd_ba;
  logic [`DDR3_ROW_BITS-1:0]   cmd_adr;
  logic [`DDR3_TID_BITS-1:0]   cmd_tid;
  logic                        cmd_seq;
  logic                        gate_acc;

  ddr3_req_decode ddr3_req_decode_inst (
    .clock       (clock),
    .rst_n       (rst_n),
    .wr_req_i    (wr_req_i),
    .wr_lst_i    (wr_lst_i),
    .wr_tid_i    (wr_tid_i),
    .wr_adr_i    (wr_adr_i),
    .rd_req_i    (rd_req_i),
    .rd_lst_i    (rd_lst_i),
    .rd_tid_i    (rd_tid_i),
    .rd_adr_i    (rd_adr_i),
    .byp_req_i   (byp_req_i),
    .byp_lst_i   (byp_lst_i),
    .byp_tid_i   (byp_tid_i),
    .byp_adr_i   (byp_adr_i),
    .wr_ack_o    (wr_ack_o),
    .rd_ack_o    (rd_ack_o),
    .byp_ack_o   (byp_ack_o),
    .seq_open_i  (seq_open),
    .seq_port_i  (seq_port),
    .slot_take_i (slot_take),
    .beat_done_i (beat_done),
    .beat_port_i (beat_port),
    .slot_vld_o  (slot_vld),
    .slot_port_o (slot_port),
    .slot_lst_o  (slot_lst),
    .slot_tid_o  (slot_tid),
    .slot_bank_o (slot_bank),
    .slot_row_o  (slot_row),
    .slot_col_o  (slot_col)
  );

  ddr3_cmd_fsm ddr3_cmd_fsm_inst (
    .clock       (clock),
    .rst_n       (rst_n),
    .slot_vld_i  (slot_vld),
    .slot_port_i (slot_port),
    .slot_lst_i  (slot_lst),
    .slot_tid_i  (slot_tid),
    .slot_bank_i (slot_bank),
    .slot_row_i  (slot_row),
    .slot_col_i  (slot_col),
    .slot_take_o (slot_take),
    .seq_open_o  (seq_open),
    .seq_port_o  (seq_port),
    .beat_done_o (beat_done),
    .beat_port_o (beat_port),
    .ddl_ref_i   (ddl_ref_i),
    .cmd_req_o   (cmd_req),
    .cmd_o       (cmd),
    .cmd_ba_o    (cmd_ba),
    .cmd_adr_o   (cmd_adr),
    .cmd_tid_o   (cmd_tid),
    .cmd_seq_o   (cmd_seq),
    .gate_acc_i  (gate_acc)
  );

  ddr3_timing_gate ddr3_timing_gate_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .cmd_req_i  (cmd_req),
    .cmd_i      (cmd),
    .cmd_ba_i   (cmd_ba),
    .cmd_adr_i  (cmd_adr),
    .cmd_tid_i  (cmd_tid),
    .cmd_seq_i  (cmd_seq),
    .gate_acc_o (gate_acc),
    .ddl_req_o  (ddl_req_o),
    .ddl_cmd_o  (ddl_cmd_o),
    .ddl_ba_o   (ddl_ba_o),
    .ddl_adr_o  (ddl_adr_o),
    .ddl_tid_o  (ddl_tid_o),
    .ddl_seq_o  (ddl_seq_o),
    .ddl_rdy_i  (ddl_rdy_i)
  );

endmodule

// ==== rtl/ddr3_timing_gate.sv ====
`timescale 1ns/1ps
`include "ddr3_sched_macros.svh"

module ddr3_timing_gate
  import ddr3_sched_pkg::*;
(
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic                        cmd_req_i,
  input  ddr3_cmd_t                   cmd_i,
  input  logic [`DDR3_BANK_BITS-1:0]  cmd_ba_i,
  input  logic [`DDR3_ROW_BITS-1:0]   cmd_adr_i,
  input  logic [`DDR3_TID_BITS-1:0]   cmd_tid_i,
  input  logic                        cmd_seq_i,
  output logic                        gate_acc_o,
  output logic                        ddl_req_o,
  output ddr3_cmd_t                   ddl_cmd_o,
  output logic [`DDR3_BANK_BITS-1:0]  ddl_ba_o,
  output logic [`DDR3_ROW_BITS-1:0]   ddl_adr_o,
  output logic [`DDR3_TID_BITS-1:0]   ddl_tid_o,
  output logic                        ddl_seq_o,
  input  logic                        ddl_rdy_i
);

  // tRFC is the longest gap
  localparam int GAP_W = $clog2(`DDR3_T_RFC + 1);

  logic [GAP_W-1:0] gap_q;
  logic [GAP_W-1:0] gap_load_w;
  logic             gap_ok_w;

  // Count loads T-1 so that the next command lands exactly T cycles
  // after the accepted one when ready stays high
  always_comb begin
    case (cmd_i)
      CMD_ACTV: gap_load_w = GAP_W'(`DDR3_T_RCD - 1);
      CMD_REFR: gap_load_w = GAP_W'(`DDR3_T_RFC - 1);
      CMD_READ, CMD_WRIT: begin
        // Only an auto-precharge access closes the row
        gap_load_w = cmd_adr_i[`DDR3_AP_BIT] ? GAP_W'(`DDR3_T_RP - 1) : '0;
      end
      default: gap_load_w = '0;
    endcase
  end

  assign gap_ok_w   = gap_q == '0;
  assign ddl_req_o  = cmd_req_i && gap_ok_w;
  assign gate_acc_o = ddl_req_o && ddl_rdy_i;

  // Fields come straight from the FSM, which holds them until accepted
  assign ddl_cmd_o  = cmd_i;
  assign ddl_ba_o   = cmd_ba_i;
  assign ddl_adr_o  = cmd_adr_i;
  assign ddl_tid_o  = cmd_tid_i;
  assign ddl_seq_o  = cmd_seq_i;

  // Counter runs every cycle, independent of ready
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      gap_q <= '0;
    end else if (gate_acc_o) begin
      gap_q <= gap_load_w;
    end else if (!gap_ok_w) begin
      gap_q <= gap_q - 1'b1;
    end
  end

endmodule
